/* issue_params.svh */
/*
 * issue stage parameters
 * widths and counts shared by the integer issue and operand-read stage
 */

`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// --------------------
// datapath widths
// --------------------

// data word and pc width
`define ISSUE_XLEN 32

// register index width and register count
`define ISSUE_REG_ADDR_BITS 5
`define ISSUE_NR_REGS 32

// --------------------
// scoreboard and commit
// --------------------

// scoreboard tag width
`define ISSUE_TRANS_ID_BITS 3

// commit ports writing the register file
`define ISSUE_NR_COMMIT_PORTS 2

`endif

/* issue_pkg.sv */
/*
 * issue stage types
 * width typedefs, unit and operator encodings and the packed
 * structs passed between scoreboard, issue stage and units
 */

`include "issue_params.svh"

package issue_pkg;

    // --------------------
    // width typedefs
    // --------------------
    typedef logic [`ISSUE_XLEN-1:0]          xlen_t;
    typedef logic [`ISSUE_REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`ISSUE_TRANS_ID_BITS-1:0] trans_id_t;

    // functional unit that executes an instruction
    typedef enum logic [2:0] {
        NONE      = 3'd0,
        LOAD      = 3'd1,
        STORE     = 3'd2,
        ALU       = 3'd3,
        CTRL_FLOW = 3'd4,
        MULT      = 3'd5,
        CSR       = 3'd6
    } fu_e;

    // operator code, not decoded in this stage
    typedef enum logic [3:0] {
        ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SRA,
        SLTS, SLTU, EQ, NE, MUL, LW, SW, CSR_RW
    } fu_op_e;

    // --------------------
    // packed structs
    // --------------------

    // scoreboard entry offered for issue
    typedef struct packed {
        fu_e       fu;
        fu_op_e    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        xlen_t     pc;
        trans_id_t trans_id;
        // exception already raised upstream
        logic      ex_valid;
        logic      is_compressed;
    } issue_instr_t;

    // operands and control handed to the units
    typedef struct packed {
        fu_e       fu;
        fu_op_e    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one register file write from commit
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } commit_port_t;

    // pending writer per register, NONE when no write is outstanding
    typedef fu_e [`ISSUE_NR_REGS-1:0] clobber_t;

    // one strobe per unit
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } unit_valid_t;

endpackage

/* int_regfile.sv */
/*
 * integer register file
 * two asynchronous read ports and one write port per commit port,
 * x0 reads as zero and ignores writes
 */

`timescale 1ns/10ps

`include "issue_params.svh"

module int_regfile (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // read addresses for operand a and b
    input  issue_pkg::reg_addr_t     raddr_a_i,
    input  issue_pkg::reg_addr_t     raddr_b_i,
    // write ports from commit
    input  issue_pkg::commit_port_t  commit_i [`ISSUE_NR_COMMIT_PORTS],
    output issue_pkg::xlen_t         rdata_a_o,
    output issue_pkg::xlen_t         rdata_b_o
);

    // register array, entry 0 never written
    issue_pkg::xlen_t regs_q [`ISSUE_NR_REGS];

    // --------------------
    // write ports
    // --------------------

    // ports handled in order so the higher port wins on a collision
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            regs_q <= '{default: '0};
        end else begin
            for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
                // x0 stays zero
                if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
                    regs_q[commit_i[p].waddr] <= commit_i[p].wdata;
                end
            end
        end
    end

    // --------------------
    // read ports
    // --------------------

    // no write-through, a commit shows up the cycle after
    always_comb begin
        rdata_a_o = regs_q[raddr_a_i];
        rdata_b_o = regs_q[raddr_b_i];
        // hardwired zero for x0
        if (raddr_a_i == '0) begin
            rdata_a_o = '0;
        end
        if (raddr_b_i == '0) begin
            rdata_b_o = '0;
        end
    end

endmodule

/* issue_hazard_check.sv */
/*
 * issue hazard check
 * looks for RAW hazards on rs1/rs2, WAW hazards on rd and a busy
 * unit, selects forwarding from the scoreboard and makes issue ack
 */

`timescale 1ns/10ps

`include "issue_params.svh"

module issue_hazard_check (
    input  issue_pkg::issue_instr_t  issue_instr_i,
    input  logic                     issue_valid_i,
    // scoreboard answer for the sources
    input  logic                     rs1_valid_i,
    input  logic                     rs2_valid_i,
    input  issue_pkg::clobber_t      clobber_i,
    input  issue_pkg::commit_port_t  commit_i [`ISSUE_NR_COMMIT_PORTS],
    input  logic                     flu_ready_i,
    input  logic                     lsu_ready_i,
    // a MULT went out last cycle
    input  logic                     mult_valid_i,
    output issue_pkg::reg_addr_t     rs1_o,
    output issue_pkg::reg_addr_t     rs2_o,
    output logic                     fwd_rs1_o,
    output logic                     fwd_rs2_o,
    output logic                     issue_ack_o
);

    logic stall;
    logic fu_busy;
    logic rd_free;

    // scoreboard lookup by source index
    assign rs1_o = issue_instr_i.rs1;
    assign rs2_o = issue_instr_i.rs2;

    // --------------------
    // unit readiness
    // --------------------
    always_comb begin
        case (issue_instr_i.fu)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW,
            issue_pkg::MULT, issue_pkg::CSR:
                fu_busy = ~flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE:
                fu_busy = ~lsu_ready_i;
            // NONE needs no unit
            default:
                fu_busy = 1'b0;
        endcase
    end

    // --------------------
    // RAW check
    // --------------------
    always_comb begin
        stall     = 1'b0;
        fwd_rs1_o = 1'b0;
        fwd_rs2_o = 1'b0;
        // zimm in rs1 is an immediate, nothing to wait for
        if (!issue_instr_i.use_zimm && (clobber_i[issue_instr_i.rs1] != issue_pkg::NONE)) begin
            // CSR results only reach us through the register file
            if (rs1_valid_i && (clobber_i[issue_instr_i.rs1] != issue_pkg::CSR)) begin
                fwd_rs1_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
        if (clobber_i[issue_instr_i.rs2] != issue_pkg::NONE) begin
            if (rs2_valid_i && (clobber_i[issue_instr_i.rs2] != issue_pkg::CSR)) begin
                fwd_rs2_o = 1'b1;
            end else begin
                stall = 1'b1;
            end
        end
    end

    // --------------------
    // WAW check
    // --------------------

    // rd free when nobody owns it or it is being committed right now
    always_comb begin
        rd_free = (clobber_i[issue_instr_i.rd] == issue_pkg::NONE);
        for (int p = 0; p < `ISSUE_NR_COMMIT_PORTS; p++) begin
            if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
                rd_free = 1'b1;
            end
        end
    end

    // --------------------
    // issue decision
    // --------------------
    always_comb begin
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && rd_free) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less instructions just drain
            if (issue_instr_i.ex_valid || (issue_instr_i.fu == issue_pkg::NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // only a MULT may follow a MULT on the shared result bus
        if (mult_valid_i && (issue_instr_i.fu != issue_pkg::MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

/* operand_select.sv */
/*
 * operand select
 * builds the next unit data word from the register file, the
 * scoreboard forwarding values, pc, zimm and the immediate
 */

`timescale 1ns/10ps

`include "issue_params.svh"

module operand_select (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  issue_pkg::issue_instr_t  issue_instr_i,
    // forwarded values from the scoreboard
    input  issue_pkg::xlen_t         rs1_i,
    input  issue_pkg::xlen_t         rs2_i,
    input  logic                     fwd_rs1_i,
    input  logic                     fwd_rs2_i,
    input  issue_pkg::commit_port_t  commit_i [`ISSUE_NR_COMMIT_PORTS],
    output issue_pkg::fu_data_t      next_data_o
);

    issue_pkg::xlen_t rf_rdata_a;
    issue_pkg::xlen_t rf_rdata_b;

    // --------------------
    // register file
    // --------------------
    int_regfile int_regfile_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (issue_instr_i.rs1),
        .raddr_b_i (issue_instr_i.rs2),
        .commit_i  (commit_i),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b)
    );

    // --------------------
    // operand muxes
    // --------------------
    always_comb begin
        next_data_o.fu       = issue_instr_i.fu;
        next_data_o.op       = issue_instr_i.op;
        next_data_o.trans_id = issue_instr_i.trans_id;
        next_data_o.imm      = issue_instr_i.imm;
        // operand a, zimm first then pc then forwarding
        if (issue_instr_i.use_zimm) begin
            next_data_o.operand_a = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_BITS){1'b0}},
                                     issue_instr_i.rs1};
        end else if (issue_instr_i.use_pc) begin
            next_data_o.operand_a = issue_instr_i.pc;
        end else if (fwd_rs1_i) begin
            next_data_o.operand_a = rs1_i;
        end else begin
            next_data_o.operand_a = rf_rdata_a;
        end
        // stores and branches keep rs2 in operand b, their imm rides in imm
        if (issue_instr_i.use_imm && (issue_instr_i.fu != issue_pkg::STORE)
                && (issue_instr_i.fu != issue_pkg::CTRL_FLOW)) begin
            next_data_o.operand_b = issue_instr_i.imm;
        end else if (fwd_rs2_i) begin
            next_data_o.operand_b = rs2_i;
        end else begin
            next_data_o.operand_b = rf_rdata_b;
        end
    end

endmodule

/* issue_ex_register.sv */
/*
 * ID/EX register
 * registers the unit data every cycle and raises one valid strobe
 * for the unit of an accepted instruction, cleared on flush
 */

`timescale 1ns/10ps

module issue_ex_register (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  issue_pkg::issue_instr_t  issue_instr_i,
    // valid and ack both high this cycle
    input  logic                     issue_accept_i,
    input  issue_pkg::fu_data_t      next_data_i,
    output issue_pkg::fu_data_t      fu_data_o,
    output issue_pkg::unit_valid_t   unit_valid_o,
    output logic                     mult_valid_o,
    output issue_pkg::xlen_t         pc_o,
    output logic                     is_compressed_o
);

    issue_pkg::unit_valid_t unit_valid_q;
    issue_pkg::fu_e         fu_q;
    issue_pkg::fu_op_e      op_q;
    issue_pkg::xlen_t       operand_a_q;
    issue_pkg::xlen_t       operand_b_q;
    issue_pkg::xlen_t       imm_q;
    issue_pkg::trans_id_t   trans_id_q;

    // --------------------
    // unit strobes
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            unit_valid_q <= '0;
            fu_q         <= issue_pkg::NONE;
        end else begin
            fu_q         <= next_data_i.fu;
            // strobes last one cycle
            unit_valid_q <= '0;
            // an instruction with an exception goes to no unit
            if (issue_accept_i && !issue_instr_i.ex_valid) begin
                case (issue_instr_i.fu)
                    issue_pkg::ALU:                   unit_valid_q.alu    <= 1'b1;
                    issue_pkg::CTRL_FLOW:             unit_valid_q.branch <= 1'b1;
                    issue_pkg::LOAD, issue_pkg::STORE: unit_valid_q.lsu    <= 1'b1;
                    issue_pkg::MULT:                  unit_valid_q.mult   <= 1'b1;
                    issue_pkg::CSR:                   unit_valid_q.csr    <= 1'b1;
                    default: ;
                endcase
            end
            // a flushed instruction must not start a unit
            if (flush_i) begin
                unit_valid_q <= '0;
            end
        end
    end

    // --------------------
    // payload
    // --------------------

    // follows the input every cycle, qualified by the strobes
    always_ff @(posedge clk_i) begin
        op_q            <= next_data_i.op;
        operand_a_q     <= next_data_i.operand_a;
        operand_b_q     <= next_data_i.operand_b;
        imm_q           <= next_data_i.imm;
        trans_id_q      <= next_data_i.trans_id;
        pc_o            <= issue_instr_i.pc;
        is_compressed_o <= issue_instr_i.is_compressed;
    end

    assign fu_data_o.fu        = fu_q;
    assign fu_data_o.op        = op_q;
    assign fu_data_o.operand_a = operand_a_q;
    assign fu_data_o.operand_b = operand_b_q;
    assign fu_data_o.imm       = imm_q;
    assign fu_data_o.trans_id  = trans_id_q;

    assign unit_valid_o = unit_valid_q;
    // fed back for the MULT follow rule
    assign mult_valid_o = unit_valid_q.mult;

endmodule

/* issue_stage_top.sv */
/*
 * integer issue stage
 * hazard check, operand select with register file and the ID/EX
 * register between the scoreboard and the functional units
 */

`timescale 1ns/10ps

`include "issue_params.svh"

module issue_stage_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // issue handshake with the scoreboard
    input  issue_pkg::issue_instr_t  issue_instr_i,
    input  logic                     issue_valid_i,
    output logic                     issue_ack_o,
    // source lookup in the scoreboard
    output issue_pkg::reg_addr_t     rs1_o,
    input  issue_pkg::xlen_t         rs1_i,
    input  logic                     rs1_valid_i,
    output issue_pkg::reg_addr_t     rs2_o,
    input  issue_pkg::xlen_t         rs2_i,
    input  logic                     rs2_valid_i,
    input  issue_pkg::clobber_t      clobber_i,
    // register file writes
    input  issue_pkg::commit_port_t  commit_i [`ISSUE_NR_COMMIT_PORTS],
    // unit readiness
    input  logic                     flu_ready_i,
    input  logic                     lsu_ready_i,
    // to the units
    output issue_pkg::fu_data_t      fu_data_o,
    output issue_pkg::unit_valid_t   unit_valid_o,
    output issue_pkg::xlen_t         pc_o,
    output logic                     is_compressed_o
);

    logic                fwd_rs1;
    logic                fwd_rs2;
    logic                issue_ack;
    logic                issue_accept;
    logic                mult_valid;
    issue_pkg::fu_data_t next_data;

    assign issue_ack_o  = issue_ack;
    assign issue_accept = issue_valid_i & issue_ack;

    issue_hazard_check issue_hazard_check_inst (
        .issue_instr_i (issue_instr_i),
        .issue_valid_i (issue_valid_i),
        .rs1_valid_i   (rs1_valid_i),
        .rs2_valid_i   (rs2_valid_i),
        .clobber_i     (clobber_i),
        .commit_i      (commit_i),
        .flu_ready_i   (flu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .mult_valid_i  (mult_valid),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .fwd_rs1_o     (fwd_rs1),
        .fwd_rs2_o     (fwd_rs2),
        .issue_ack_o   (issue_ack)
    );

    operand_select operand_select_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .issue_instr_i (issue_instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .fwd_rs1_i     (fwd_rs1),
        .fwd_rs2_i     (fwd_rs2),
        .commit_i      (commit_i),
        .next_data_o   (next_data)
    );

    issue_ex_register issue_ex_register_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .issue_instr_i   (issue_instr_i),
        .issue_accept_i  (issue_accept),
        .next_data_i     (next_data),
        .fu_data_o       (fu_data_o),
        .unit_valid_o    (unit_valid_o),
        .mult_valid_o    (mult_valid),
        .pc_o            (pc_o),
        .is_compressed_o (is_compressed_o)
    );

endmodule

/* issue_stage_asserts.sv */
/*
 * issue stage assertions
 * protocol checks on the top-level ports, bound into issue_stage_top
 */

`timescale 1ns/10ps

module issue_stage_asserts (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    issue_valid_i,
    input  logic                    issue_ack_o,
    input  issue_pkg::fu_e          issue_fu_i,
    input  issue_pkg::unit_valid_t  unit_valid_o
);

    // at most one unit started per cycle
    a_unit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(unit_valid_o))
        else $error("unit_valid_o has more than one strobe set");

    // a flushed cycle starts no unit
    a_flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> (unit_valid_o == '0))
        else $error("unit strobe raised after a flush");

    // only a MULT may issue right behind a MULT
    a_mult_follow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(issue_valid_i && issue_ack_o && unit_valid_o.mult
          && (issue_fu_i != issue_pkg::MULT)))
        else $error("non-MULT instruction issued behind a MULT");

endmodule

bind issue_stage_top issue_stage_asserts issue_stage_asserts_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_i),
    .issue_ack_o   (issue_ack_o),
    .issue_fu_i    (issue_instr_i.fu),
    .unit_valid_o  (unit_valid_o)
);

/* tb_issue_stage.sv */
/*
 * issue stage testbench
 * replays the golden vectors against the DUT, checks ack and the
 * source lookup in the drive cycle and the registered outputs one
 * cycle later
 */

`timescale 1ns/10ps

`include "issue_params.svh"

module tb_issue_stage;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 1;
    localparam int MAX_VECTORS  = 64;
    localparam int NR_FIELDS    = 31;

    // --------------------
    // golden file columns
    // --------------------
    typedef enum int {
        F_TEST, F_FU, F_OP, F_RS1, F_RS2, F_RD,
        F_IMM, F_UIMM, F_UPC, F_UZIMM, F_PC,
        F_EXV, F_VLD, F_CRS1, F_CRS2, F_CRD,
        F_R1V, F_R1D, F_R2V, F_R2D,
        F_CWE, F_CADR, F_CDAT, F_FLU, F_LSU,
        F_FLUSH, F_ACK, F_UV, F_CHK, F_A, F_B
    } golden_col_e;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    flush_i;
    issue_pkg::issue_instr_t issue_instr_i;
    logic                    issue_valid_i;
    logic                    issue_ack_o;
    issue_pkg::reg_addr_t    rs1_o;
    issue_pkg::reg_addr_t    rs2_o;
    issue_pkg::xlen_t        rs1_i;
    issue_pkg::xlen_t        rs2_i;
    logic                    rs1_valid_i;
    logic                    rs2_valid_i;
    issue_pkg::clobber_t     clobber_i;
    issue_pkg::commit_port_t commit_i [`ISSUE_NR_COMMIT_PORTS];
    logic                    flu_ready_i;
    logic                    lsu_ready_i;
    issue_pkg::fu_data_t     fu_data_o;
    issue_pkg::unit_valid_t  unit_valid_o;
    issue_pkg::xlen_t        pc_o;
    logic                    is_compressed_o;

    logic [31:0] vec_mem [MAX_VECTORS][NR_FIELDS];
    logic [31:0] row_buf [NR_FIELDS];
    int          nr_vectors;
    int          errors;
    int          test_errors;
    int          tests_failed;
    bit          loaded;

    // random tag and size bit of the vector last driven
    issue_pkg::trans_id_t sent_trans_id;
    logic                 sent_compressed;

    issue_stage_top issue_stage_top_inst (
        .clk_i, .rst_ni, .flush_i, .issue_instr_i, .issue_valid_i, .issue_ack_o,
        .rs1_o, .rs1_i, .rs1_valid_i, .rs2_o, .rs2_i, .rs2_valid_i, .clobber_i,
        .commit_i, .flu_ready_i, .lsu_ready_i, .fu_data_o, .unit_valid_o, .pc_o,
        .is_compressed_o
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // hex tokens of one line into row_buf
    task automatic parse_line(input string line, output int count);
        logic [31:0] acc;
        bit          in_tok;
        byte         c;
        count  = 0;
        acc    = '0;
        in_tok = 1'b0;
        for (int i = 0; i <= line.len(); i++) begin
            c = (i < line.len()) ? line[i] : 8'h20;
            if (c >= "0" && c <= "9") begin
                acc    = {acc[27:0], 4'(c - "0")};
                in_tok = 1'b1;
            end else if (c >= "a" && c <= "f") begin
                acc    = {acc[27:0], 4'(c - "a" + 10)};
                in_tok = 1'b1;
            end else if (in_tok) begin
                if (count < NR_FIELDS) begin
                    row_buf[count] = acc;
                end
                count++;
                acc    = '0;
                in_tok = 1'b0;
            end
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    count;
        string line;
        fd = $fopen("issue_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file could not be opened");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    parse_line(line, count);
                    if (count == NR_FIELDS && nr_vectors < MAX_VECTORS) begin
                        vec_mem[nr_vectors] = row_buf;
                        nr_vectors++;
                    end else if (count != 0) begin
                        $display("golden line with %0d fields skipped", count);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // drive one vector, other registers stay NONE in the clobber list
    task automatic apply_vector(input int k);
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            clobber_i[r] = issue_pkg::NONE;
        end
        sent_trans_id   = 3'($urandom);
        sent_compressed = 1'($urandom);
        issue_instr_i.fu            = issue_pkg::fu_e'(vec_mem[k][F_FU][2:0]);
        issue_instr_i.op            = issue_pkg::fu_op_e'(vec_mem[k][F_OP][3:0]);
        issue_instr_i.rs1           = vec_mem[k][F_RS1][4:0];
        issue_instr_i.rs2           = vec_mem[k][F_RS2][4:0];
        issue_instr_i.rd            = vec_mem[k][F_RD][4:0];
        issue_instr_i.imm           = vec_mem[k][F_IMM];
        issue_instr_i.use_imm       = vec_mem[k][F_UIMM][0];
        issue_instr_i.use_pc        = vec_mem[k][F_UPC][0];
        issue_instr_i.use_zimm      = vec_mem[k][F_UZIMM][0];
        issue_instr_i.pc            = vec_mem[k][F_PC];
        issue_instr_i.trans_id      = sent_trans_id;
        issue_instr_i.ex_valid      = vec_mem[k][F_EXV][0];
        issue_instr_i.is_compressed = sent_compressed;
        issue_valid_i               = vec_mem[k][F_VLD][0];
        if (vec_mem[k][F_CRS1] != 0)
            clobber_i[issue_instr_i.rs1] = issue_pkg::fu_e'(vec_mem[k][F_CRS1][2:0]);
        if (vec_mem[k][F_CRS2] != 0)
            clobber_i[issue_instr_i.rs2] = issue_pkg::fu_e'(vec_mem[k][F_CRS2][2:0]);
        if (vec_mem[k][F_CRD] != 0)
            clobber_i[issue_instr_i.rd] = issue_pkg::fu_e'(vec_mem[k][F_CRD][2:0]);
        rs1_valid_i = vec_mem[k][F_R1V][0];
        rs2_valid_i = vec_mem[k][F_R2V][0];
        // filler data where nothing is forwarded
        rs1_i = rs1_valid_i ? vec_mem[k][F_R1D] : $urandom;
        rs2_i = rs2_valid_i ? vec_mem[k][F_R2D] : $urandom;
        commit_i[0].we    = vec_mem[k][F_CWE][0];
        commit_i[0].waddr = vec_mem[k][F_CADR][4:0];
        commit_i[0].wdata = vec_mem[k][F_CDAT];
        commit_i[1].we    = 1'b0;
        commit_i[1].waddr = 5'($urandom);
        commit_i[1].wdata = $urandom;
        flu_ready_i = vec_mem[k][F_FLU][0];
        lsu_ready_i = vec_mem[k][F_LSU][0];
        flush_i     = vec_mem[k][F_FLUSH][0];
    endtask

    // combinational answers in the drive cycle
    task automatic check_issue(input int k);
        if (issue_ack_o !== vec_mem[k][F_ACK][0]) begin
            $display("FAIL test %0h: issue_ack_o got %h expected %h",
                     vec_mem[k][F_TEST], issue_ack_o, vec_mem[k][F_ACK][0]);
            test_errors++;
        end
        if (rs1_o !== vec_mem[k][F_RS1][4:0]) begin
            $display("FAIL test %0h: rs1_o got %h expected %h",
                     vec_mem[k][F_TEST], rs1_o, vec_mem[k][F_RS1][4:0]);
            test_errors++;
        end
        if (rs2_o !== vec_mem[k][F_RS2][4:0]) begin
            $display("FAIL test %0h: rs2_o got %h expected %h",
                     vec_mem[k][F_TEST], rs2_o, vec_mem[k][F_RS2][4:0]);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int k);
        if (unit_valid_o !== vec_mem[k][F_UV][4:0]) begin
            $display("FAIL test %0h: unit_valid_o got %h expected %h",
                     vec_mem[k][F_TEST], unit_valid_o, vec_mem[k][F_UV][4:0]);
            test_errors++;
        end
        if (vec_mem[k][F_CHK][0] && fu_data_o.operand_a !== vec_mem[k][F_A]) begin
            $display("FAIL test %0h: fu_data_o.operand_a got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.operand_a, vec_mem[k][F_A]);
            test_errors++;
        end
        if (vec_mem[k][F_CHK][0] && fu_data_o.operand_b !== vec_mem[k][F_B]) begin
            $display("FAIL test %0h: fu_data_o.operand_b got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.operand_b, vec_mem[k][F_B]);
            test_errors++;
        end
        // payload follows the input every cycle, accepted or not
        if (fu_data_o.fu !== vec_mem[k][F_FU][2:0]) begin
            $display("FAIL test %0h: fu_data_o.fu got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.fu, vec_mem[k][F_FU][2:0]);
            test_errors++;
        end
        if (fu_data_o.op !== vec_mem[k][F_OP][3:0]) begin
            $display("FAIL test %0h: fu_data_o.op got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.op, vec_mem[k][F_OP][3:0]);
            test_errors++;
        end
        if (fu_data_o.imm !== vec_mem[k][F_IMM]) begin
            $display("FAIL test %0h: fu_data_o.imm got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.imm, vec_mem[k][F_IMM]);
            test_errors++;
        end
        if (fu_data_o.trans_id !== sent_trans_id) begin
            $display("FAIL test %0h: fu_data_o.trans_id got %h expected %h",
                     vec_mem[k][F_TEST], fu_data_o.trans_id, sent_trans_id);
            test_errors++;
        end
        if (pc_o !== vec_mem[k][F_PC]) begin
            $display("FAIL test %0h: pc_o got %h expected %h",
                     vec_mem[k][F_TEST], pc_o, vec_mem[k][F_PC]);
            test_errors++;
        end
        if (is_compressed_o !== sent_compressed) begin
            $display("FAIL test %0h: is_compressed_o got %h expected %h",
                     vec_mem[k][F_TEST], is_compressed_o, sent_compressed);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int k);
        if (test_errors == 0) begin
            $display("test %0h passed", vec_mem[k][F_TEST]);
        end else begin
            $display("test %0h failed with %0d errors", vec_mem[k][F_TEST], test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin
        wait (loaded);
        repeat (nr_vectors * 4 + RESET_CYCLES) @(posedge clk_i);
        $display("watchdog expired before all vectors were applied");
        $display("Finished with errors");
        $finish;
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        void'($urandom(25260));
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        nr_vectors   = 0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        issue_instr_i = '0;
        issue_valid_i = 1'b0;
        rs1_i         = '0;
        rs2_i         = '0;
        rs1_valid_i   = 1'b0;
        rs2_valid_i   = 1'b0;
        for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
            clobber_i[r] = issue_pkg::NONE;
        end
        commit_i[0]   = '0;
        commit_i[1]   = '0;
        flu_ready_i   = 1'b1;
        lsu_ready_i   = 1'b1;
        load_golden();
        if (nr_vectors == 0) begin
            $display("golden file holds no vectors");
            errors++;
        end
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;
        for (int i = 0; i < nr_vectors; i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            // previous vector's registered results are settled here
            if (i > 0) begin
                check_outputs(i - 1);
                finish_test(i - 1);
            end
            apply_vector(i);
            @(negedge clk_i);
            check_issue(i);
        end
        if (nr_vectors > 0) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            check_outputs(nr_vectors - 1);
            finish_test(nr_vectors - 1);
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 nr_vectors, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* issue_stage_top.f */
+incdir+.
issue_pkg.sv
int_regfile.sv
issue_hazard_check.sv
operand_select.sv
issue_ex_register.sv
issue_stage_top.sv
issue_stage_asserts.sv
tb_issue_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_issue_stage
FILELIST  = issue_stage_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* issue_golden.txt */
# test fu op rs1 rs2 rd imm uimm upc uzimm pc exv vld crs1 crs2 crd r1v r1d r2v r2d
# cwe cadr cdat flu lsu flush | expected: ack uv chk operand_a operand_b (all hex)
01 0 0 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 01 11111111 1 1 0 0 00 0 0 0
02 0 0 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 02 22222222 1 1 0 0 00 0 0 0
03 0 0 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 00 deadbeef 1 1 0 0 00 0 0 0
04 3 0 01 02 03 1000 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 10 1 11111111 22222222
05 3 0 00 01 03 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 10 1 0 11111111
06 3 0 01 02 03 0 0 0 0 0 0 1 3 0 0 1 aaaa5555 0 0 0 00 0 1 1 0 1 10 1 aaaa5555 22222222
07 3 0 01 02 03 0 0 0 0 0 0 1 3 0 0 0 0 0 0 0 00 0 1 1 0 0 00 0 0 0
08 3 0 01 02 03 0 0 0 0 0 0 1 6 0 0 1 aaaa5555 0 0 0 00 0 1 1 0 0 00 0 0 0
09 3 0 01 02 03 0 0 0 0 0 0 1 0 0 3 0 0 0 0 0 00 0 1 1 0 0 00 0 0 0
0a 3 0 01 02 03 0 0 0 0 0 0 1 0 0 3 0 0 0 0 1 03 33333333 1 1 0 1 10 1 11111111 22222222
0b 3 0 01 02 03 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 0 1 0 0 00 0 0 0
0c 5 c 01 02 03 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 0 1 0 0 00 0 0 0
0d 1 d 01 02 03 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 0 0 0 00 0 0 0
0e 0 0 01 02 03 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 0 0 0 1 00 0 0 0
0f 3 0 01 02 03 0 0 0 0 0 1 1 0 0 0 0 0 0 0 0 00 0 0 1 0 1 00 0 0 0
10 6 f 1f 00 04 0 0 0 1 0 0 1 6 0 0 0 0 0 0 0 00 0 1 1 0 1 01 1 1f 0
11 3 0 00 00 05 1000 1 1 0 80000010 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 10 1 80000010 1000
12 2 e 01 03 00 10 1 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 04 1 11111111 33333333
13 5 c 01 02 06 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 02 1 11111111 22222222
14 5 c 01 02 07 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 02 1 11111111 22222222
15 3 0 01 02 08 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 0 00 0 0 0
16 3 0 02 01 08 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 0 1 10 1 22222222 11111111
17 3 0 01 02 08 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 00 0 1 1 1 1 00 1 11111111 22222222
18 0 0 00 00 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1 1 0 0 00 0 0 0
